// ==== common/gpu_params.svh ====
`ifndef GPU_PARAMS_SVH
`define GPU_PARAMS_SVH

// Bus and DRAM word widths
`define GPU_DATA_W 32
`define GPU_ADDR_W 32

// Screen coordinates are unsigned and live in the low bits of a word
`define GPU_CORD_W 10
`define GPU_FB_WIDTH  640
`define GPU_FB_HEIGHT 480

// Triangle record is v0x, v0y, v1x, v1y, v2x, v2y, color
`define GPU_TRI_WORDS 7

// Host register byte offsets
`define GPU_ADDR_CONTROL     32'h0000_0000
`define GPU_ADDR_STATUS      32'h0000_0004
`define GPU_ADDR_VERTEX_BASE 32'h0000_0008
`define GPU_ADDR_TRI_COUNT   32'h0000_000C
`define GPU_ADDR_FB_BASE     32'h0000_0014

// Product of two coordinate deltas plus sign and carry
`define GPU_EDGE_W (2 * `GPU_CORD_W + 2)

`endif

// ==== common/gpu_pkg.sv ====
`include "gpu_params.svh"

package gpu_pkg;

  // Data word on the host bus and DRAM
  typedef logic [`GPU_DATA_W-1:0] word_t;

  // Byte address
  typedef logic [`GPU_ADDR_W-1:0] addr_t;

  typedef logic [`GPU_CORD_W-1:0] coord_t;   // Unsigned screen coordinate
  typedef logic [`GPU_DATA_W-1:0] color_t;   // Flat triangle color

  // Triangle index or count
  typedef logic [15:0] tri_cnt_t;

  typedef logic signed [`GPU_EDGE_W-1:0] edge_t;   // Signed edge function value

  // Per-draw sequencing
  typedef enum logic [1:0] {
    PIPE_IDLE,
    PIPE_FETCH,
    PIPE_RASTER,
    PIPE_DONE
  } pipe_state_t;

endpackage

// ==== common/gpu_ifs.sv ====
`timescale 1ns/1ps
`include "gpu_params.svh"

// Read path from vertex fetch to the DRAM port
interface mem_rd_if;
  logic                   req;
  logic [`GPU_ADDR_W-1:0] addr;
  logic [`GPU_DATA_W-1:0] rdata;
  logic                   rvalid;   // One cycle after req

  modport client (output req, output addr, input rdata, input rvalid);
  modport port   (input req, input addr, output rdata, output rvalid);
endinterface

// Current triangle, held stable until the next fetch
interface tri_if;
  logic [`GPU_CORD_W-1:0] v0x;
  logic [`GPU_CORD_W-1:0] v0y;
  logic [`GPU_CORD_W-1:0] v1x;
  logic [`GPU_CORD_W-1:0] v1y;
  logic [`GPU_CORD_W-1:0] v2x;
  logic [`GPU_CORD_W-1:0] v2y;
  logic [`GPU_DATA_W-1:0] color;

  modport src (output v0x, output v0y, output v1x, output v1y,
               output v2x, output v2y, output color);
  modport dst (input v0x, input v0y, input v1x, input v1y,
               input v2x, input v2y, input color);
endinterface

// Covered pixels, one strobe per fragment
interface frag_if;
  logic                   valid;
  logic [`GPU_CORD_W-1:0] x;
  logic [`GPU_CORD_W-1:0] y;
  logic [`GPU_DATA_W-1:0] color;

  modport src (output valid, output x, output y, output color);
  modport dst (input valid, input x, input y, input color);
endinterface

// ==== logic/gpu_regs.sv ====
`timescale 1ns/1ps
`include "gpu_params.svh"

module gpu_regs import gpu_pkg::*; (
  input  logic     clk,
  input  logic     glbl_rst_n,

  // Host bus
  input  logic     i_bus_we,
  input  addr_t    i_bus_addr,
  input  word_t    i_bus_wdata,
  output word_t    o_bus_rdata,

  // Pipeline status
  input  logic     i_busy,
  input  logic     i_draw_done,

  // Draw setup
  output logic     o_start,
  output addr_t    o_vertex_base,
  output tri_cnt_t o_tri_count,
  output addr_t    o_fb_base
);

  addr_t    vertex_base;
  tri_cnt_t tri_count;
  addr_t    fb_base;
  logic     start_q;
  logic     irq;        // Sticky until STATUS is written
  logic     wr_control;
  logic     wr_status;

  assign wr_control = i_bus_we && (i_bus_addr == `GPU_ADDR_CONTROL);
  assign wr_status  = i_bus_we && (i_bus_addr == `GPU_ADDR_STATUS);

  always_ff @(posedge clk or negedge glbl_rst_n) begin
    if (!glbl_rst_n) begin
      vertex_base <= '0;
      tri_count   <= '0;
      fb_base     <= '0;
      start_q     <= 1'b0;
      irq         <= 1'b0;
    end else begin
      // Start only from idle, and never twice in a row
      start_q <= wr_control && i_bus_wdata[0] && !i_busy && !start_q;

      if (i_bus_we) begin
        case (i_bus_addr)
          `GPU_ADDR_VERTEX_BASE: vertex_base <= i_bus_wdata;
          `GPU_ADDR_TRI_COUNT:   tri_count   <= tri_cnt_t'(i_bus_wdata);
          `GPU_ADDR_FB_BASE:     fb_base     <= i_bus_wdata;
          default: ;
        endcase
      end

      if (i_draw_done) begin
        irq <= 1'b1;             // Completion wins over a clear
      end else if (wr_status) begin
        irq <= 1'b0;
      end
    end
  end

  always_comb begin
    case (i_bus_addr)
      `GPU_ADDR_CONTROL:     o_bus_rdata = word_t'(start_q);
      `GPU_ADDR_STATUS:      o_bus_rdata = word_t'({irq, i_busy});
      `GPU_ADDR_VERTEX_BASE: o_bus_rdata = vertex_base;
      `GPU_ADDR_TRI_COUNT:   o_bus_rdata = word_t'(tri_count);
      `GPU_ADDR_FB_BASE:     o_bus_rdata = fb_base;
      default:               o_bus_rdata = '0;
    endcase
  end

  assign o_start       = start_q;
  assign o_vertex_base = vertex_base;
  assign o_tri_count   = tri_count;
  assign o_fb_base     = fb_base;

  // A start must land while the pipeline is still idle
  assert property (@(posedge clk) disable iff (!glbl_rst_n) $rose(o_start) |-> !i_busy)
    else $error("start raised while pipeline busy");

endmodule

// ==== logic/pipe_ctrl.sv ====
`timescale 1ns/1ps

module pipe_ctrl import gpu_pkg::*; (
  input  logic     clk,
  input  logic     glbl_rst_n,
  input  logic     i_start,
  input  tri_cnt_t i_tri_count,
  output logic     o_fetch_go,
  input  logic     i_fetch_done,
  output logic     o_rast_go,
  input  logic     i_rast_done,
  output logic     o_draw_done,
  output logic     o_busy,
  output tri_cnt_t o_tri_index
);

  pipe_state_t state;
  tri_cnt_t    tri_index;
  tri_cnt_t    tri_total;   // Count captured at start
  logic        fetch_go;
  logic        rast_go;

  always_ff @(posedge clk or negedge glbl_rst_n) begin
    if (!glbl_rst_n) begin
      state     <= PIPE_IDLE;
      tri_index <= '0;
      tri_total <= '0;
      fetch_go  <= 1'b0;
      rast_go   <= 1'b0;
    end else begin
      fetch_go <= 1'b0;
      rast_go  <= 1'b0;
      case (state)
        PIPE_IDLE: begin
          if (i_start) begin
            state     <= PIPE_FETCH;
            tri_index <= '0;
            tri_total <= i_tri_count;
            fetch_go  <= (i_tri_count != '0);   // Empty draw skips the fetch
          end
        end
        PIPE_FETCH: begin
          if (i_fetch_done) begin
            state   <= PIPE_RASTER;
            rast_go <= 1'b1;
          end else if (tri_total == '0) begin
            state <= PIPE_DONE;
          end
        end
        PIPE_RASTER: begin
          if (i_rast_done) begin
            if (tri_index == tri_total - 16'd1) begin
              state <= PIPE_DONE;
            end else begin
              state     <= PIPE_FETCH;
              tri_index <= tri_index + 16'd1;
              fetch_go  <= 1'b1;
            end
          end
        end
        PIPE_DONE: state <= PIPE_IDLE;
        default:   state <= PIPE_IDLE;
      endcase
    end
  end

  assign o_fetch_go  = fetch_go;
  assign o_rast_go   = rast_go;
  assign o_draw_done = (state == PIPE_DONE);   // DONE lasts exactly one cycle
  assign o_busy      = (state != PIPE_IDLE);
  assign o_tri_index = tri_index;

  // Completion strobes from the worker blocks must match the current stage
  assert property (@(posedge clk) disable iff (!glbl_rst_n) i_fetch_done |-> state == PIPE_FETCH)
    else $error("fetch_done outside FETCH");
  assert property (@(posedge clk) disable iff (!glbl_rst_n) i_rast_done |-> state == PIPE_RASTER)
    else $error("rast_done outside RASTER");

endmodule

// ==== raster/vertex_fetch.sv ====
`timescale 1ns/1ps
`include "gpu_params.svh"

module vertex_fetch import gpu_pkg::*; (
  input  logic     clk,
  input  logic     glbl_rst_n,
  input  logic     i_go,
  input  addr_t    i_vertex_base,
  input  tri_cnt_t i_tri_index,
  output logic     o_done,
  mem_rd_if.client mem,
  tri_if.src       tri_out
);

  localparam int               IDX_W     = $clog2(`GPU_TRI_WORDS);
  localparam logic [IDX_W-1:0] LAST_WORD = IDX_W'(`GPU_TRI_WORDS - 1);
  localparam addr_t            REC_BYTES = addr_t'(4 * `GPU_TRI_WORDS);

  logic             issuing;
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;
  addr_t            rd_addr;
  word_t            rec_q [`GPU_TRI_WORDS];

  // One read request per cycle
  always_ff @(posedge clk or negedge glbl_rst_n) begin
    if (!glbl_rst_n) begin
      issuing <= 1'b0;
      rd_idx  <= '0;
      rd_addr <= '0;
    end else if (i_go) begin
      issuing <= 1'b1;
      rd_idx  <= '0;
      rd_addr <= i_vertex_base + addr_t'(i_tri_index) * REC_BYTES;
    end else if (issuing) begin
      rd_idx  <= rd_idx + 1'b1;
      rd_addr <= rd_addr + addr_t'(4);
      if (rd_idx == LAST_WORD) begin
        issuing <= 1'b0;
      end
    end
  end

  assign mem.req  = issuing;
  assign mem.addr = rd_addr;

  // Returning words fill the record and wrap back to word 0
  always_ff @(posedge clk or negedge glbl_rst_n) begin
    if (!glbl_rst_n) begin
      wr_idx <= '0;
    end else if (mem.rvalid) begin
      wr_idx <= (wr_idx == LAST_WORD) ? '0 : wr_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (mem.rvalid) begin
      rec_q[wr_idx] <= mem.rdata;
    end
  end

  assign o_done = mem.rvalid && (wr_idx == LAST_WORD);   // Last word arriving

  assign tri_out.v0x   = rec_q[0][`GPU_CORD_W-1:0];
  assign tri_out.v0y   = rec_q[1][`GPU_CORD_W-1:0];
  assign tri_out.v1x   = rec_q[2][`GPU_CORD_W-1:0];
  assign tri_out.v1y   = rec_q[3][`GPU_CORD_W-1:0];
  assign tri_out.v2x   = rec_q[4][`GPU_CORD_W-1:0];
  assign tri_out.v2y   = rec_q[5][`GPU_CORD_W-1:0];
  assign tri_out.color = rec_q[6];

endmodule

// ==== raster/rasterizer.sv ====
`timescale 1ns/1ps
`include "gpu_params.svh"

module rasterizer import gpu_pkg::*; (
  input  logic clk,
  input  logic glbl_rst_n,
  input  logic i_go,
  output logic o_done,
  tri_if.dst   tri_in,
  frag_if.src  frag
);

  localparam coord_t X_LAST = coord_t'(`GPU_FB_WIDTH - 1);
  localparam coord_t Y_LAST = coord_t'(`GPU_FB_HEIGHT - 1);

  logic   scanning;
  logic   done_q;
  coord_t cur_x;
  coord_t cur_y;
  coord_t box_x0;
  coord_t box_x1;
  coord_t box_y1;
  coord_t bb_x0;
  coord_t bb_x1;
  coord_t bb_y0;
  coord_t bb_y1;
  logic   box_empty;
  edge_t  area;
  edge_t  e0;
  edge_t  e1;
  edge_t  e2;
  logic   covered;

  function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
    coord_t m;
    m = (a < b) ? a : b;
    return (c < m) ? c : m;
  endfunction

  function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
    coord_t m;
    m = (a > b) ? a : b;
    return (c > m) ? c : m;
  endfunction

  // Signed side of p relative to the directed edge a->b
  function automatic edge_t edge_fn(input coord_t ax, input coord_t ay,
                                    input coord_t bx, input coord_t by,
                                    input coord_t px, input coord_t py);
    logic signed [`GPU_CORD_W:0] dx_ab;
    logic signed [`GPU_CORD_W:0] dy_ab;
    logic signed [`GPU_CORD_W:0] dx_ap;
    logic signed [`GPU_CORD_W:0] dy_ap;
    edge_t                       prod_a;
    edge_t                       prod_b;
    dx_ab  = $signed({1'b0, bx}) - $signed({1'b0, ax});
    dy_ab  = $signed({1'b0, by}) - $signed({1'b0, ay});
    dx_ap  = $signed({1'b0, px}) - $signed({1'b0, ax});
    dy_ap  = $signed({1'b0, py}) - $signed({1'b0, ay});
    prod_a = edge_t'(dx_ab) * edge_t'(dy_ap);
    prod_b = edge_t'(dy_ab) * edge_t'(dx_ap);
    return prod_a - prod_b;
  endfunction

  // Bounding box clipped to the screen
  always_comb begin
    bb_x0 = min3(tri_in.v0x, tri_in.v1x, tri_in.v2x);
    bb_y0 = min3(tri_in.v0y, tri_in.v1y, tri_in.v2y);
    bb_x1 = max3(tri_in.v0x, tri_in.v1x, tri_in.v2x);
    bb_y1 = max3(tri_in.v0y, tri_in.v1y, tri_in.v2y);
    if (bb_x1 > X_LAST) bb_x1 = X_LAST;
    if (bb_y1 > Y_LAST) bb_y1 = Y_LAST;
    box_empty = (bb_x0 > X_LAST) || (bb_y0 > Y_LAST);   // Fully off-screen
  end

  assign area = edge_fn(tri_in.v0x, tri_in.v0y, tri_in.v1x, tri_in.v1y, tri_in.v2x, tri_in.v2y);
  assign e0   = edge_fn(tri_in.v0x, tri_in.v0y, tri_in.v1x, tri_in.v1y, cur_x, cur_y);
  assign e1   = edge_fn(tri_in.v1x, tri_in.v1y, tri_in.v2x, tri_in.v2y, cur_x, cur_y);
  assign e2   = edge_fn(tri_in.v2x, tri_in.v2y, tri_in.v0x, tri_in.v0y, cur_x, cur_y);

  // Either winding counts as inside
  assign covered = (area != 0) &&
                   (((e0 >= 0) && (e1 >= 0) && (e2 >= 0)) ||
                    ((e0 <= 0) && (e1 <= 0) && (e2 <= 0)));

  always_ff @(posedge clk or negedge glbl_rst_n) begin
    if (!glbl_rst_n) begin
      scanning <= 1'b0;
      done_q   <= 1'b0;
      cur_x    <= '0;
      cur_y    <= '0;
      box_x0   <= '0;
      box_x1   <= '0;
      box_y1   <= '0;
    end else begin
      done_q <= 1'b0;
      if (i_go) begin
        if (box_empty) begin
          done_q <= 1'b1;
        end else begin
          scanning <= 1'b1;
          cur_x    <= bb_x0;
          cur_y    <= bb_y0;
          box_x0   <= bb_x0;
          box_x1   <= bb_x1;
          box_y1   <= bb_y1;
        end
      end else if (scanning) begin
        if (cur_x == box_x1) begin
          cur_x <= box_x0;   // Next row
          if (cur_y == box_y1) begin
            scanning <= 1'b0;
            done_q   <= 1'b1;
          end else begin
            cur_y <= cur_y + 1'b1;
          end
        end else begin
          cur_x <= cur_x + 1'b1;
        end
      end
    end
  end

  assign frag.valid = scanning && covered;
  assign frag.x     = cur_x;
  assign frag.y     = cur_y;
  assign frag.color = tri_in.color;
  assign o_done     = done_q;

  assert property (@(posedge clk) disable iff (!glbl_rst_n)
                   frag.valid |-> (frag.x <= X_LAST) && (frag.y <= Y_LAST))
    else $error("fragment outside the screen");

endmodule

// ==== logic/pixel_writer.sv ====
`timescale 1ns/1ps
`include "gpu_params.svh"

module pixel_writer import gpu_pkg::*; (
  input  logic     clk,
  input  logic     glbl_rst_n,
  input  addr_t    i_fb_base,
  frag_if.dst      frag,
  mem_rd_if.port   mem,

  // DRAM
  output logic     o_dram_we,
  output addr_t    o_dram_addr,
  output word_t    o_dram_wdata,
  input  word_t    i_dram_rdata
);

  addr_t pix_index;
  addr_t pix_addr;

  // Row-major with four bytes per pixel
  assign pix_index = addr_t'(frag.y) * addr_t'(`GPU_FB_WIDTH) + addr_t'(frag.x);
  assign pix_addr  = i_fb_base + (pix_index << 2);

  always_comb begin
    o_dram_we    = frag.valid;
    o_dram_addr  = '0;
    o_dram_wdata = '0;
    if (frag.valid) begin
      o_dram_addr  = pix_addr;
      o_dram_wdata = frag.color;
    end else if (mem.req) begin
      o_dram_addr = mem.addr;   // Fetch read
    end
  end

  assign mem.rdata = i_dram_rdata;

  always_ff @(posedge clk or negedge glbl_rst_n) begin
    if (!glbl_rst_n) begin
      mem.rvalid <= 1'b0;
    end else begin
      mem.rvalid <= mem.req && !frag.valid;   // Data lands one cycle after the address
    end
  end

  // Fetch and raster phases are never active together
  assert property (@(posedge clk) disable iff (!glbl_rst_n) !(frag.valid && mem.req))
    else $error("fragment collides with a fetch read");

endmodule

// ==== logic/gpu_top.sv ====
`timescale 1ns/1ps

module gpu_top import gpu_pkg::*; (
  input  logic  clk,
  input  logic  glbl_rst_n,

  // Host bus
  input  logic  i_bus_we,
  input  addr_t i_bus_addr,
  input  word_t i_bus_wdata,
  output word_t o_bus_rdata,

  // DRAM
  output logic  o_dram_we,
  output addr_t o_dram_addr,
  output word_t o_dram_wdata,
  input  word_t i_dram_rdata
);

  logic     start;
  logic     busy;
  logic     draw_done;
  logic     fetch_go;
  logic     fetch_done;
  logic     rast_go;
  logic     rast_done;
  addr_t    vertex_base;
  addr_t    fb_base;
  tri_cnt_t tri_count;
  tri_cnt_t tri_index;

  mem_rd_if mem_rd ();
  tri_if    tri_bus ();
  frag_if   frag_bus ();

  gpu_regs regs_inst (
    .clk           (clk),
    .glbl_rst_n    (glbl_rst_n),
    .i_bus_we      (i_bus_we),
    .i_bus_addr    (i_bus_addr),
    .i_bus_wdata   (i_bus_wdata),
    .o_bus_rdata   (o_bus_rdata),
    .i_busy        (busy),
    .i_draw_done   (draw_done),
    .o_start       (start),
    .o_vertex_base (vertex_base),
    .o_tri_count   (tri_count),
    .o_fb_base     (fb_base)
  );

  pipe_ctrl ctrl_inst (
    .clk          (clk),
    .glbl_rst_n   (glbl_rst_n),
    .i_start      (start),
    .i_tri_count  (tri_count),
    .o_fetch_go   (fetch_go),
    .i_fetch_done (fetch_done),
    .o_rast_go    (rast_go),
    .i_rast_done  (rast_done),
    .o_draw_done  (draw_done),
    .o_busy       (busy),
    .o_tri_index  (tri_index)
  );

  vertex_fetch vf_inst (
    .clk           (clk),
    .glbl_rst_n    (glbl_rst_n),
    .i_go          (fetch_go),
    .i_vertex_base (vertex_base),
    .i_tri_index   (tri_index),
    .o_done        (fetch_done),
    .mem           (mem_rd.client),
    .tri_out       (tri_bus.src)
  );

  rasterizer rast_inst (
    .clk        (clk),
    .glbl_rst_n (glbl_rst_n),
    .i_go       (rast_go),
    .o_done     (rast_done),
    .tri_in     (tri_bus.dst),
    .frag       (frag_bus.src)
  );

  pixel_writer pw_inst (
    .clk          (clk),
    .glbl_rst_n   (glbl_rst_n),
    .i_fb_base    (fb_base),
    .frag         (frag_bus.dst),
    .mem          (mem_rd.port),
    .o_dram_we    (o_dram_we),
    .o_dram_addr  (o_dram_addr),
    .o_dram_wdata (o_dram_wdata),
    .i_dram_rdata (i_dram_rdata)
  );

endmodule

// ==== sim/gpu_tb_tasks.svh ====
`ifndef GPU_TB_TASKS_SVH
`define GPU_TB_TASKS_SVH

function automatic int draw_limit(input int n_tris);
  return n_tris * (MAX_BOX_AREA + 16) + 32;   // Fetch and handshake slack per triangle
endfunction

task automatic clear_expect();
  exp_addr_q.delete();
  exp_data_q.delete();
endtask

// Reference coverage over the clipped box in row-major order
task automatic expect_tri(input int x0, input int y0, input int x1, input int y1,
                          input int x2, input int y2, input word_t color);
  int area;
  int e0;
  int e1;
  int e2;
  int xmin;
  int xmax;
  int ymin;
  int ymax;
  area = edge_val(x0, y0, x1, y1, x2, y2);
  xmin = smallest3(x0, x1, x2);
  ymin = smallest3(y0, y1, y2);
  xmax = largest3(x0, x1, x2);
  ymax = largest3(y0, y1, y2);
  if (xmax > `GPU_FB_WIDTH - 1) xmax = `GPU_FB_WIDTH - 1;
  if (ymax > `GPU_FB_HEIGHT - 1) ymax = `GPU_FB_HEIGHT - 1;
  for (int y = ymin; y <= ymax; y++) begin
    for (int x = xmin; x <= xmax; x++) begin
      e0 = edge_val(x0, y0, x1, y1, x, y);
      e1 = edge_val(x1, y1, x2, y2, x, y);
      e2 = edge_val(x2, y2, x0, y0, x, y);
      if (area != 0 &&
          ((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0))) begin
        exp_addr_q.push_back(FBASE + addr_t'(4 * (y * `GPU_FB_WIDTH + x)));
        exp_data_q.push_back(color);
      end
    end
  end
endtask

// Store one 7-word record and predict its pixels
task automatic add_tri(input int idx, input int x0, input int y0, input int x1, input int y1,
                       input int x2, input int y2, input word_t color);
  addr_t rec;
  rec = VBASE + addr_t'(idx * 4 * `GPU_TRI_WORDS);
  dram_mem[rec]          = word_t'(x0);
  dram_mem[rec + 32'd4]  = word_t'(y0);
  dram_mem[rec + 32'd8]  = word_t'(x1);
  dram_mem[rec + 32'd12] = word_t'(y1);
  dram_mem[rec + 32'd16] = word_t'(x2);
  dram_mem[rec + 32'd20] = word_t'(y2);
  dram_mem[rec + 32'd24] = color;
  expect_tri(x0, y0, x1, y1, x2, y2, color);
endtask

task automatic start_draw(input int n_tris);
  bus_write(`GPU_ADDR_STATUS, '0);   // Drop irq from the previous draw
  bus_write(`GPU_ADDR_VERTEX_BASE, VBASE);
  bus_write(`GPU_ADDR_FB_BASE, FBASE);
  bus_write(`GPU_ADDR_TRI_COUNT, word_t'(n_tris));
  wr_addr_q.delete();
  wr_data_q.delete();
  bus_write(`GPU_ADDR_CONTROL, 32'h1);
endtask

task automatic wait_draw(input string test, input int limit);
  word_t st;
  int    cycles;
  st     = '0;
  cycles = 0;
  while (st[1] !== 1'b1 && cycles < limit) begin
    bus_read(`GPU_ADDR_STATUS, st);
    cycles++;
  end
  if (st[1] !== 1'b1) begin
    n_errors++;
    $display("%s: draw did not finish within %0d cycles", test, limit);
  end
endtask

task automatic compare_writes(input string test);
  int   n;
  logic ok;
  compare_word(test, "write count", word_t'(exp_addr_q.size()), word_t'(wr_addr_q.size()));
  n  = (exp_addr_q.size() < wr_addr_q.size()) ? exp_addr_q.size() : wr_addr_q.size();
  ok = 1'b1;
  for (int i = 0; i < n && ok; i++) begin
    n_checks++;
    if (wr_addr_q[i] !== exp_addr_q[i] || wr_data_q[i] !== exp_data_q[i]) begin
      n_errors++;
      ok = 1'b0;
      $display("CHECK FAILED %s: write %0d expected %h=%h actual %h=%h", test, i,
               exp_addr_q[i], exp_data_q[i], wr_addr_q[i], wr_data_q[i]);
    end
  end
endtask

task automatic verify_register_readback();
  string name;
  int    errs;
  word_t rd;
  name = "register_readback";
  errs = n_errors;
  bus_read(`GPU_ADDR_STATUS, rd);
  compare_word(name, "STATUS after reset", '0, rd);
  bus_read(`GPU_ADDR_CONTROL, rd);
  compare_word(name, "CONTROL after reset", '0, rd);
  bus_write(`GPU_ADDR_VERTEX_BASE, 32'h0002_0040);
  bus_read(`GPU_ADDR_VERTEX_BASE, rd);
  compare_word(name, "VERTEX_BASE", 32'h0002_0040, rd);
  bus_write(`GPU_ADDR_TRI_COUNT, 32'h0000_1234);
  bus_read(`GPU_ADDR_TRI_COUNT, rd);
  compare_word(name, "TRI_COUNT", 32'h0000_1234, rd);
  bus_write(`GPU_ADDR_FB_BASE, 32'h0030_0000);
  bus_read(`GPU_ADDR_FB_BASE, rd);
  compare_word(name, "FB_BASE", 32'h0030_0000, rd);
  finish_test(name, errs);
endtask

task automatic draw_single_triangle();
  string name;
  int    errs;
  int    first_count;
  name = "single_triangle";
  errs = n_errors;
  clear_expect();
  add_tri(0, 10, 10, 25, 12, 14, 28, 32'hff20_8040);
  start_draw(1);
  wait_draw(name, draw_limit(1));
  compare_writes(name);
  first_count = wr_addr_q.size();
  // Same triangle with the opposite winding
  clear_expect();
  add_tri(0, 10, 10, 14, 28, 25, 12, 32'hff20_8040);
  start_draw(1);
  wait_draw(name, draw_limit(1));
  compare_writes(name);
  compare_word(name, "count across windings", word_t'(first_count), word_t'(wr_addr_q.size()));
  finish_test(name, errs);
endtask

task automatic draw_random_batch();
  string name;
  int    errs;
  int    c [6];
  name = "random_batch";
  errs = n_errors;
  clear_expect();
  for (int t = 0; t < 3; t++) begin
    for (int k = 0; k < 6; k++) begin
      c[k] = 64 + int'((lcg_next() >> 16) & 32'h1f);
    end
    add_tri(t, c[0], c[1], c[2], c[3], c[4], c[5], lcg_next());
  end
  start_draw(3);
  wait_draw(name, draw_limit(3));
  compare_writes(name);
  finish_test(name, errs);
endtask

task automatic draw_clipped_and_flat();
  string name;
  int    errs;
  name = "clipped_and_flat";
  errs = n_errors;
  clear_expect();
  add_tri(0, 620, 460, 700, 470, 630, 520, 32'h00c0_ffee);   // Crosses right and bottom edges
  start_draw(1);
  wait_draw(name, draw_limit(1));
  compare_writes(name);
  clear_expect();
  add_tri(0, 100, 100, 110, 110, 120, 120, 32'h1234_5678);   // Collinear
  start_draw(1);
  wait_draw(name, draw_limit(1));
  compare_writes(name);
  finish_test(name, errs);
endtask

task automatic verify_busy_and_irq();
  string name;
  int    errs;
  word_t st;
  name = "busy_and_irq";
  errs = n_errors;
  clear_expect();
  add_tri(0, 200, 50, 220, 56, 206, 70, 32'h8080_0101);
  start_draw(1);
  bus_read(`GPU_ADDR_STATUS, st);
  compare_word(name, "busy during draw", 32'h1, word_t'(st[0]));
  bus_write(`GPU_ADDR_CONTROL, 32'h1);   // Must be ignored
  wait_draw(name, draw_limit(1));
  repeat (64) @(posedge clk);            // Room for a wrongly started second draw
  bus_read(`GPU_ADDR_STATUS, st);
  compare_word(name, "STATUS after draw", 32'h2, st);
  compare_writes(name);
  bus_write(`GPU_ADDR_STATUS, '0);
  bus_read(`GPU_ADDR_STATUS, st);
  compare_word(name, "STATUS after clear", '0, st);
  finish_test(name, errs);
endtask

`endif

// ==== sim/tb_gpu_top.sv ====
`timescale 1ns/1ps
`include "gpu_params.svh"

module tb_gpu_top import gpu_pkg::*; ();

  localparam int    CLK_PERIOD      = 20;
  localparam int    N_TESTS         = 5;
  localparam int    MAX_BOX_AREA    = 1024;   // Random triangles stay inside 32x32
  localparam int    WATCHDOG_CYCLES = N_TESTS * MAX_BOX_AREA + 2000;
  localparam addr_t VBASE           = 32'h0001_0000;
  localparam addr_t FBASE           = 32'h0010_0000;

  logic  clk;
  logic  glbl_rst_n;
  logic  i_bus_we;
  addr_t i_bus_addr;
  word_t i_bus_wdata;
  word_t o_bus_rdata;
  logic  o_dram_we;
  addr_t o_dram_addr;
  word_t o_dram_wdata;
  word_t i_dram_rdata;

  word_t       dram_mem [addr_t];   // Sparse DRAM contents
  word_t       rd_pending = '0;
  addr_t       wr_addr_q [$];       // Every write the DUT made
  word_t       wr_data_q [$];
  addr_t       exp_addr_q [$];      // Writes the reference model predicts
  word_t       exp_data_q [$];
  logic [31:0] lcg_state;
  int          n_checks;
  int          n_errors;
  int          n_tests;
  int          n_failed;

  gpu_top i_gpu_top (
    .clk          (clk),
    .glbl_rst_n   (glbl_rst_n),
    .i_bus_we     (i_bus_we),
    .i_bus_addr   (i_bus_addr),
    .i_bus_wdata  (i_bus_wdata),
    .o_bus_rdata  (o_bus_rdata),
    .o_dram_we    (o_dram_we),
    .o_dram_addr  (o_dram_addr),
    .o_dram_wdata (o_dram_wdata),
    .i_dram_rdata (i_dram_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Unwritten locations return a pattern built from the address
  function automatic word_t dram_read(input addr_t addr);
    if (dram_mem.exists(addr)) begin
      return dram_mem[addr];
    end
    return addr ^ 32'h5a5a_5a5a;
  endfunction

  // DRAM port sampled mid-cycle
  always @(negedge clk) begin
    if (o_dram_we) begin
      dram_mem[o_dram_addr] = o_dram_wdata;
      wr_addr_q.push_back(o_dram_addr);
      wr_data_q.push_back(o_dram_wdata);
    end else begin
      rd_pending = dram_read(o_dram_addr);
    end
  end

  // Read data shows up in the cycle after its address
  initial begin
    i_dram_rdata = '0;
    forever begin
      @(posedge clk);
      #1;
      i_dram_rdata = rd_pending;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Cross product of (b - a) and (p - a)
  function automatic int edge_val(input int ax, input int ay, input int bx, input int by,
                                  input int px, input int py);
    return (bx - ax) * (py - ay) - (by - ay) * (px - ax);
  endfunction

  function automatic int smallest3(input int a, input int b, input int c);
    int m;
    m = (a < b) ? a : b;
    return (c < m) ? c : m;
  endfunction

  function automatic int largest3(input int a, input int b, input int c);
    int m;
    m = (a > b) ? a : b;
    return (c > m) ? c : m;
  endfunction

  task automatic bus_write(input addr_t addr, input word_t data);
    @(posedge clk);
    #1;
    i_bus_we    = 1'b1;
    i_bus_addr  = addr;
    i_bus_wdata = data;
    @(posedge clk);
    #1;
    i_bus_we    = 1'b0;
    i_bus_addr  = '0;
    i_bus_wdata = '0;
  endtask

  task automatic bus_read(input addr_t addr, output word_t data);
    @(posedge clk);
    #1;
    i_bus_addr = addr;
    @(negedge clk);
    data = o_bus_rdata;
  endtask

  task automatic compare_word(input string test, input string what,
                              input word_t exp, input word_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s: %s expected %h actual %h", test, what, exp, act);
    end
  endtask

  task automatic finish_test(input string test, input int errs_before);
    n_tests++;
    if (n_errors == errs_before) begin
      $display("PASS %s", test);
    end else begin
      n_failed++;
      $display("FAIL %s", test);
    end
  endtask

  `include "gpu_tb_tasks.svh"

  initial begin
    glbl_rst_n  = 1'b0;
    i_bus_we    = 1'b0;
    i_bus_addr  = '0;
    i_bus_wdata = '0;
    lcg_state   = 32'he86f53aa;
    n_checks    = 0;
    n_errors    = 0;
    n_tests     = 0;
    n_failed    = 0;
    repeat (3) @(posedge clk);
    #1;
    glbl_rst_n = 1'b1;

    verify_register_readback();
    draw_single_triangle();
    draw_random_batch();
    draw_clipped_and_flat();
    verify_busy_and_irq();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             n_tests, n_failed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+common
+incdir+sim
common/gpu_pkg.sv
common/gpu_ifs.sv
logic/gpu_regs.sv
logic/pipe_ctrl.sv
raster/vertex_fetch.sv
raster/rasterizer.sv
logic/pixel_writer.sv
logic/gpu_top.sv
sim/tb_gpu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the GPU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_gpu_top -o tb_gpu_top

out=$(./obj_dir/tb_gpu_top)
echo "$out"

if echo "$out" | grep -q "NO ERRORS"; then
  exit 0
fi
exit 1
